// ==== common/tinygpu_params.svh ====
`ifndef TINYGPU_PARAMS_SVH
`define TINYGPU_PARAMS_SVH

// pixels per line, blanking included
`define H_TOTAL 800
// lines per frame
`define V_TOTAL 525

// hsync low window on x
`define HS_START 656
`define HS_END 752
// vsync low window on y
`define VS_START 490
`define VS_END 492

// visible image in the top left corner
`define IMG_W 320
`define IMG_H 240

// next-line fetch starts here, right after the active pixels
`define FETCH_X 320

// flash holds the two count nibbles, then padding, image from here
`define FLASH_IMG_BASE 4
// front buffer start in ram
`define RAM_FRONT_BASE 0

// requests allowed in flight toward the memory port
`define MEM_CREDITS 8

`endif

// ==== common/tinygpu_pkg.sv ====
`default_nettype none

package tinygpu_pkg;

  // one pixel or one memory data nibble
  typedef logic [3:0] nibble_t;

  // nibble address, flash and ram alike
  typedef logic [23:0] mem_addr_t;

  // screen x or y
  typedef logic [9:0] pix_coord_t;

  typedef enum logic {
    CMD_READ,
    CMD_WRITE
  } mem_cmd_e;

  typedef enum logic {
    DEV_FLASH,
    DEV_RAM
  } mem_dev_e;

  // boot sequence: header, copy, clear, wait for credits
  typedef enum logic [2:0] {
    LD_HDR,
    LD_SIZE,
    LD_COPY,
    LD_CLEAR,
    LD_DRAIN,
    LD_DONE
  } loader_state_e;

  // per-line fetch
  typedef enum logic [1:0] {
    FE_IDLE,
    FE_ISSUE,
    FE_DRAIN
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== design/vga_timing.sv ====
`default_nettype none

`include "tinygpu_params.svh"

module vga_timing (
  input  logic                    clk,
  input  logic                    rst_n,
  output tinygpu_pkg::pix_coord_t o_x,
  output tinygpu_pkg::pix_coord_t o_y,
  output logic                    o_hsync,
  output logic                    o_vsync
);

  import tinygpu_pkg::*;

  pix_coord_t x_next;
  pix_coord_t y_next;

  // next position, y steps only on the x wrap
  always_comb begin
    x_next = o_x + 1'b1;
    y_next = o_y;
    if (o_x == pix_coord_t'(`H_TOTAL - 1)) begin
      x_next = '0;
      if (o_y == pix_coord_t'(`V_TOTAL - 1)) begin
        y_next = '0;
      end else begin
        y_next = o_y + 1'b1;
      end
    end
  end

  // syncs decoded from the next position
  // so they line up with the registered x,y
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_x     <= '0;
      o_y     <= '0;
      o_hsync <= 1'b1;
      o_vsync <= 1'b1;
    end else begin
      o_x     <= x_next;
      o_y     <= y_next;
      // active low pulses
      o_hsync <= !((x_next >= pix_coord_t'(`HS_START)) && (x_next < pix_coord_t'(`HS_END)));
      o_vsync <= !((y_next >= pix_coord_t'(`VS_START)) && (y_next < pix_coord_t'(`VS_END)));
    end
  end

endmodule

`default_nettype wire

// ==== design/mem_credit_port.sv ====
`default_nettype none

`include "tinygpu_params.svh"

module mem_credit_port (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_boot_done,
  // loader side
  input  logic                   i_ld_req,
  input  tinygpu_pkg::mem_cmd_e  i_ld_cmd,
  input  tinygpu_pkg::mem_dev_e  i_ld_dev,
  input  tinygpu_pkg::mem_addr_t i_ld_addr,
  input  tinygpu_pkg::nibble_t   i_ld_wdata,
  output logic                   o_ld_grant,
  // fetcher side, ram reads only
  input  logic                   i_fe_req,
  input  tinygpu_pkg::mem_addr_t i_fe_addr,
  output logic                   o_fe_grant,
  // external memory port
  input  logic                   i_mem_credit,
  output logic                   o_mem_req,
  output tinygpu_pkg::mem_cmd_e  o_mem_cmd,
  output tinygpu_pkg::mem_dev_e  o_mem_dev,
  output tinygpu_pkg::mem_addr_t o_mem_addr,
  output tinygpu_pkg::nibble_t   o_mem_wdata
);

  import tinygpu_pkg::*;

  // 0..8 credits
  logic [3:0] credits;
  logic       has_credit;
  logic       issue;

  assign has_credit = (credits != 4'd0);

  // loader owns the port during boot, fetcher after
  assign o_ld_grant = !i_boot_done && i_ld_req && has_credit;
  assign o_fe_grant = i_boot_done && i_fe_req && has_credit;
  assign issue      = o_ld_grant || o_fe_grant;

  // request leaves in the grant cycle
  assign o_mem_req   = issue;
  assign o_mem_cmd   = i_boot_done ? CMD_READ : i_ld_cmd;
  assign o_mem_dev   = i_boot_done ? DEV_RAM : i_ld_dev;
  assign o_mem_addr  = i_boot_done ? i_fe_addr : i_ld_addr;
  // fetcher never writes
  assign o_mem_wdata = i_boot_done ? nibble_t'(0) : i_ld_wdata;

  // one credit per request out, one back per retired request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= 4'(`MEM_CREDITS);
    end else begin
      credits <= credits - {3'd0, issue} + {3'd0, i_mem_credit};
    end
  end

endmodule

`default_nettype wire

// ==== loader/image_loader.sv ====
`default_nettype none

`include "tinygpu_params.svh"

module image_loader (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_grant,
  input  tinygpu_pkg::nibble_t   i_rdata,
  input  logic                   i_rvalid,
  input  logic                   i_credit,
  output logic                   o_req,
  output tinygpu_pkg::mem_cmd_e  o_cmd,
  output tinygpu_pkg::mem_dev_e  o_dev,
  output tinygpu_pkg::mem_addr_t o_addr,
  output tinygpu_pkg::nibble_t   o_wdata,
  output logic                   o_boot_done
);

  import tinygpu_pkg::*;

  loader_state_e state;
  // nibble indices inside the 320x240 image
  logic [16:0]   rd_idx;
  logic [16:0]   wr_idx;
  logic [16:0]   total;
  // header reads sent and returned
  logic [1:0]    hdr_sent;
  logic [1:0]    hdr_got;
  nibble_t       hdr_hi;
  nibble_t       hdr_lo;
  logic [7:0]    raw_count;
  logic [7:0]    line_count;
  // returned flash nibbles waiting for their ram write
  nibble_t       queue [`MEM_CREDITS];
  logic [2:0]    q_wptr;
  logic [2:0]    q_rptr;
  logic [3:0]    q_cnt;
  logic          q_push;
  logic          q_pop;
  // requests granted but not yet retired
  logic [3:0]    out_cnt;
  logic          can_load;
  logic          granted;

  // a new request may be loaded once the current one is gone
  assign can_load   = !o_req || i_grant;
  assign granted    = o_req && i_grant;
  assign q_push     = (state == LD_COPY) && i_rvalid;
  assign q_pop      = (state == LD_COPY) && can_load && (q_cnt != 4'd0);
  // count is two nibbles, high one first, capped at the image height
  assign raw_count  = {hdr_hi, hdr_lo};
  assign line_count = (raw_count > 8'(`IMG_H)) ? 8'(`IMG_H) : raw_count;

  always_ff @(posedge clk) begin
    if (q_push) begin
      queue[q_wptr] <= i_rdata;
    end
    if ((state == LD_HDR) && i_rvalid) begin
      if (hdr_got == 2'd0) begin
        hdr_hi <= i_rdata;
      end else begin
        hdr_lo <= i_rdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= LD_HDR;
      rd_idx      <= '0;
      wr_idx      <= '0;
      total       <= '0;
      hdr_sent    <= '0;
      hdr_got     <= '0;
      q_wptr      <= '0;
      q_rptr      <= '0;
      q_cnt       <= '0;
      out_cnt     <= '0;
      o_req       <= 1'b0;
      o_cmd       <= CMD_READ;
      o_dev       <= DEV_FLASH;
      o_addr      <= '0;
      o_wdata     <= '0;
      o_boot_done <= 1'b0;
    end else begin
      if (q_push) begin
        q_wptr <= q_wptr + 1'b1;
      end
      if (q_pop) begin
        q_rptr <= q_rptr + 1'b1;
      end
      q_cnt <= q_cnt + {3'd0, q_push} - {3'd0, q_pop};
      // after boot the port and its credits belong to the fetcher
      if (state != LD_DONE) begin
        out_cnt <= out_cnt + {3'd0, granted} - {3'd0, i_credit};
      end

      // request register, held until granted
      if (can_load) begin
        o_req <= 1'b0;
        case (state)
          LD_HDR: begin
            if (hdr_sent != 2'd2) begin
              o_req    <= 1'b1;
              o_cmd    <= CMD_READ;
              o_dev    <= DEV_FLASH;
              o_addr   <= {22'd0, hdr_sent};
              o_wdata  <= '0;
              hdr_sent <= hdr_sent + 1'b1;
            end
          end
          LD_COPY: begin
            // drain queued data first, then top up reads
            if (q_cnt != 4'd0) begin
              o_req   <= 1'b1;
              o_cmd   <= CMD_WRITE;
              o_dev   <= DEV_RAM;
              o_addr  <= mem_addr_t'(`RAM_FRONT_BASE) + {7'd0, wr_idx};
              o_wdata <= queue[q_rptr];
              wr_idx  <= wr_idx + 1'b1;
            end else if ((rd_idx != total) && ((rd_idx - wr_idx) < 17'(`MEM_CREDITS))) begin
              o_req   <= 1'b1;
              o_cmd   <= CMD_READ;
              o_dev   <= DEV_FLASH;
              o_addr  <= mem_addr_t'(`FLASH_IMG_BASE) + {7'd0, rd_idx};
              o_wdata <= '0;
              rd_idx  <= rd_idx + 1'b1;
            end
          end
          LD_CLEAR: begin
            // black for every line past the flash image
            if (wr_idx != 17'(`IMG_W * `IMG_H)) begin
              o_req   <= 1'b1;
              o_cmd   <= CMD_WRITE;
              o_dev   <= DEV_RAM;
              o_addr  <= mem_addr_t'(`RAM_FRONT_BASE) + {7'd0, wr_idx};
              o_wdata <= '0;
              wr_idx  <= wr_idx + 1'b1;
            end
          end
          default: begin
          end
        endcase
      end

      case (state)
        LD_HDR: begin
          if (i_rvalid) begin
            hdr_got <= hdr_got + 1'b1;
          end
          if (hdr_got == 2'd2) begin
            state <= LD_SIZE;
          end
        end
        LD_SIZE: begin
          // lines * 320 as two shifts
          total <= {1'b0, line_count, 8'd0} + {3'd0, line_count, 6'd0};
          state <= LD_COPY;
        end
        LD_COPY: begin
          if (wr_idx == total) begin
            state <= LD_CLEAR;
          end
        end
        LD_CLEAR: begin
          if (wr_idx == 17'(`IMG_W * `IMG_H)) begin
            state <= LD_DRAIN;
          end
        end
        LD_DRAIN: begin
          // last write sent, its credit is the one arriving now
          if (!o_req && (out_cnt == {3'd0, i_credit})) begin
            state       <= LD_DONE;
            o_boot_done <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== scanout/line_fetcher.sv ====
`default_nettype none

`include "tinygpu_params.svh"

module line_fetcher (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_boot_done,
  input  tinygpu_pkg::pix_coord_t i_x,
  input  tinygpu_pkg::pix_coord_t i_y,
  input  logic                    i_grant,
  input  tinygpu_pkg::nibble_t    i_rdata,
  input  logic                    i_rvalid,
  output logic                    o_req,
  output tinygpu_pkg::mem_addr_t  o_addr,
  output logic                    o_wr_en,
  output logic [8:0]              o_wr_idx,
  output tinygpu_pkg::nibble_t    o_wr_data,
  output logic                    o_wr_half
);

  import tinygpu_pkg::*;

  fetch_state_e state;
  // line to be fetched and its ram start
  pix_coord_t   line;
  mem_addr_t    base;
  logic [8:0]   iss_cnt;
  logic [8:0]   ret_cnt;
  logic         can_load;
  logic         start;
  logic         last_line;

  assign can_load  = !o_req || i_grant;
  assign last_line = (i_y == pix_coord_t'(`V_TOTAL - 1));
  // line 0 is loaded during the last line of the frame
  assign line      = last_line ? pix_coord_t'(0) : i_y + 1'b1;
  // fetch at end of active pixels on lines 0..238 and the last one
  assign start     = i_boot_done && (state == FE_IDLE) &&
                     (i_x == pix_coord_t'(`FETCH_X)) &&
                     ((i_y < pix_coord_t'(`IMG_H - 1)) || last_line);

  // line base and buffer write data
  always_ff @(posedge clk) begin
    if (start) begin
      base <= mem_addr_t'(`RAM_FRONT_BASE) + mem_addr_t'({line, 8'd0}) +
              mem_addr_t'({line, 6'd0});
    end
    o_wr_idx  <= ret_cnt;
    o_wr_data <= i_rdata;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= FE_IDLE;
      iss_cnt   <= '0;
      ret_cnt   <= '0;
      o_req     <= 1'b0;
      o_addr    <= '0;
      o_wr_en   <= 1'b0;
      o_wr_half <= 1'b0;
    end else begin
      o_wr_en <= 1'b0;
      // swap halves as each new line begins
      if (i_x == pix_coord_t'(`H_TOTAL - 1)) begin
        o_wr_half <= ~o_wr_half;
      end
      if (can_load) begin
        o_req <= 1'b0;
      end

      case (state)
        FE_IDLE: begin
          if (start) begin
            iss_cnt <= '0;
            ret_cnt <= '0;
            state   <= FE_ISSUE;
          end
        end
        FE_ISSUE: begin
          // one read per grant, in address order
          if (can_load) begin
            o_req   <= 1'b1;
            o_addr  <= base + mem_addr_t'(iss_cnt);
            iss_cnt <= iss_cnt + 1'b1;
            if (iss_cnt == 9'(`IMG_W - 1)) begin
              state <= FE_DRAIN;
            end
          end
        end
        FE_DRAIN: begin
          // wait until every read of the line is back
          if (ret_cnt == 9'(`IMG_W)) begin
            state <= FE_IDLE;
          end
        end
        default: begin
          state <= FE_IDLE;
        end
      endcase

      // returns arrive in order, slot = return count
      if ((state != FE_IDLE) && i_rvalid) begin
        o_wr_en <= 1'b1;
        ret_cnt <= ret_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== scanout/pixel_out.sv ====
`default_nettype none

`include "tinygpu_params.svh"

module pixel_out (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_boot_done,
  input  tinygpu_pkg::pix_coord_t i_x,
  input  tinygpu_pkg::pix_coord_t i_y,
  input  logic                    i_wr_en,
  input  logic [8:0]              i_wr_idx,
  input  logic                    i_wr_half,
  input  tinygpu_pkg::nibble_t    i_wr_data,
  output tinygpu_pkg::nibble_t    o_pixel
);

  import tinygpu_pkg::*;

  // two line halves, one filling and one on screen
  nibble_t    line_buf [2][`IMG_W];
  // half holds a complete line
  logic [1:0] half_full;
  logic       wr_half_q;
  logic       rd_half;
  logic       active;

  assign rd_half = ~i_wr_half;
  assign active  = i_boot_done && half_full[rd_half] &&
                   (i_x < pix_coord_t'(`IMG_W)) && (i_y < pix_coord_t'(`IMG_H));
  // black outside the image, or when the line never arrived
  assign o_pixel = active ? line_buf[rd_half][i_x[8:0]] : nibble_t'(0);

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      line_buf[i_wr_half][i_wr_idx] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      half_full <= '0;
      wr_half_q <= 1'b0;
    end else begin
      wr_half_q <= i_wr_half;
      // new write target holds a stale line until refilled
      if (i_wr_half != wr_half_q) begin
        half_full[i_wr_half] <= 1'b0;
      end else if (i_wr_en && (i_wr_idx == 9'(`IMG_W - 1))) begin
        half_full[i_wr_half] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/tinygpu_top.sv ====
`default_nettype none

module tinygpu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // memory responses
  input  tinygpu_pkg::nibble_t   i_mem_rdata,
  input  logic                   i_mem_rvalid,
  input  logic                   i_mem_credit,
  // memory requests
  output logic                   o_mem_req,
  output tinygpu_pkg::mem_cmd_e  o_mem_cmd,
  output tinygpu_pkg::mem_dev_e  o_mem_dev,
  output tinygpu_pkg::mem_addr_t o_mem_addr,
  output tinygpu_pkg::nibble_t   o_mem_wdata,
  // video
  output tinygpu_pkg::nibble_t   o_pixel,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output logic                   o_boot_done
);

  import tinygpu_pkg::*;

  // screen position
  pix_coord_t x;
  pix_coord_t y;

  // loader request
  logic       ld_req;
  mem_cmd_e   ld_cmd;
  mem_dev_e   ld_dev;
  mem_addr_t  ld_addr;
  nibble_t    ld_wdata;
  logic       ld_grant;

  // fetcher request
  logic       fe_req;
  mem_addr_t  fe_addr;
  logic       fe_grant;

  // line buffer write
  logic       wr_en;
  logic [8:0] wr_idx;
  nibble_t    wr_data;
  logic       wr_half;

  vga_timing i_vga_timing (
    .clk     (clk),
    .rst_n   (rst_n),
    .o_x     (x),
    .o_y     (y),
    .o_hsync (o_hsync),
    .o_vsync (o_vsync)
  );

  image_loader i_image_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_grant     (ld_grant),
    .i_rdata     (i_mem_rdata),
    .i_rvalid    (i_mem_rvalid),
    .i_credit    (i_mem_credit),
    .o_req       (ld_req),
    .o_cmd       (ld_cmd),
    .o_dev       (ld_dev),
    .o_addr      (ld_addr),
    .o_wdata     (ld_wdata),
    .o_boot_done (o_boot_done)
  );

  line_fetcher i_line_fetcher (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_boot_done (o_boot_done),
    .i_x         (x),
    .i_y         (y),
    .i_grant     (fe_grant),
    .i_rdata     (i_mem_rdata),
    .i_rvalid    (i_mem_rvalid),
    .o_req       (fe_req),
    .o_addr      (fe_addr),
    .o_wr_en     (wr_en),
    .o_wr_idx    (wr_idx),
    .o_wr_data   (wr_data),
    .o_wr_half   (wr_half)
  );

  pixel_out i_pixel_out (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_boot_done (o_boot_done),
    .i_x         (x),
    .i_y         (y),
    .i_wr_en     (wr_en),
    .i_wr_idx    (wr_idx),
    .i_wr_half   (wr_half),
    .i_wr_data   (wr_data),
    .o_pixel     (o_pixel)
  );

  mem_credit_port i_mem_credit_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_boot_done  (o_boot_done),
    .i_ld_req     (ld_req),
    .i_ld_cmd     (ld_cmd),
    .i_ld_dev     (ld_dev),
    .i_ld_addr    (ld_addr),
    .i_ld_wdata   (ld_wdata),
    .o_ld_grant   (ld_grant),
    .i_fe_req     (fe_req),
    .i_fe_addr    (fe_addr),
    .o_fe_grant   (fe_grant),
    .i_mem_credit (i_mem_credit),
    .o_mem_req    (o_mem_req),
    .o_mem_cmd    (o_mem_cmd),
    .o_mem_dev    (o_mem_dev),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata)
  );

endmodule

`default_nettype wire

// ==== sim/tb_mem_model.sv ====
`default_nettype none

`include "tinygpu_params.svh"

module tb_mem_model #(
  parameter int LINE_COUNT = 5
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_req,
  input  tinygpu_pkg::mem_cmd_e  i_cmd,
  input  tinygpu_pkg::mem_dev_e  i_dev,
  input  tinygpu_pkg::mem_addr_t i_addr,
  input  tinygpu_pkg::nibble_t   i_wdata,
  output tinygpu_pkg::nibble_t   o_rdata,
  output logic                   o_rvalid,
  output logic                   o_credit
);

  import tinygpu_pkg::*;

  localparam int FLASH_SIZE = 2048;
  localparam int RAM_SIZE   = `IMG_W * `IMG_H;

  // nibble wide storage for both devices
  nibble_t flash [FLASH_SIZE];
  nibble_t ram   [RAM_SIZE];

  logic [31:0] lfsr = 32'h4d99_9020;
  int          cyc;
  int          last_due;

  // pending requests, oldest first
  int          due_q  [$];
  bit          wr_q   [$];
  bit          ram_q  [$];
  int          addr_q [$];
  nibble_t     data_q [$];

  // fibonacci step, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken, msb first
  task automatic draw_bits(input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic nibble_t read_nibble(input bit is_ram, input int a);
    if (is_ram) begin
      return (a < RAM_SIZE) ? ram[a] : nibble_t'(0);
    end
    return (a < FLASH_SIZE) ? flash[a] : nibble_t'(0);
  endfunction

  initial begin : fill
    int v;
    int a;
    o_rdata  <= '0;
    o_rvalid <= 1'b0;
    o_credit <= 1'b0;
    cyc      = 0;
    last_due = 0;
    // line count header, high nibble first
    flash[0] = nibble_t'(LINE_COUNT >> 4);
    flash[1] = nibble_t'(LINE_COUNT & 15);
    // padding and image, all random
    for (a = 2; a < FLASH_SIZE; a++) begin
      draw_bits(4, v);
      flash[a] = nibble_t'(v);
    end
    // stale ram, folded from every address bit
    for (a = 0; a < RAM_SIZE; a++) begin
      ram[a] = nibble_t'(a ^ (a >> 4) ^ (a >> 8) ^ (a >> 12) ^ (a >> 16) ^ 9);
    end
  end

  always @(negedge clk) begin : respond
    int      lat;
    int      due;
    logic    rv;
    logic    cr;
    nibble_t rd;
    rv = 1'b0;
    cr = 1'b0;
    rd = '0;
    if (!rst_n) begin
      due_q.delete();
      wr_q.delete();
      ram_q.delete();
      addr_q.delete();
      data_q.delete();
      last_due = cyc;
    end else begin
      if (i_req === 1'b1) begin
        draw_bits(3, lat);
        // 2..6 cycles, never ahead of the older request
        due = cyc + 2 + (lat % 5);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        due_q.push_back(due);
        wr_q.push_back(i_cmd == CMD_WRITE);
        ram_q.push_back(i_dev == DEV_RAM);
        addr_q.push_back(int'(i_addr));
        data_q.push_back(i_wdata);
      end
      // retire the oldest, credit with data for reads
      if ((due_q.size() != 0) && (due_q[0] == cyc)) begin
        cr = 1'b1;
        if (wr_q[0]) begin
          if (ram_q[0] && (addr_q[0] < RAM_SIZE)) begin
            ram[addr_q[0]] = data_q[0];
          end
        end else begin
          rv = 1'b1;
          rd = read_nibble(ram_q[0], addr_q[0]);
        end
        void'(due_q.pop_front());
        void'(wr_q.pop_front());
        void'(ram_q.pop_front());
        void'(addr_q.pop_front());
        void'(data_q.pop_front());
      end
    end
    o_rvalid <= rv;
    o_credit <= cr;
    o_rdata  <= rd;
    cyc++;
  end

endmodule

`default_nettype wire

// ==== sim/tb_tinygpu.sv ====
`default_nettype none

`include "tinygpu_params.svh"

module tb_tinygpu;

  import tinygpu_pkg::*;

  localparam int LINE_COUNT = 5;
  // flash image length, the rest is cleared
  localparam int COPY_LEN   = LINE_COUNT * `IMG_W;
  localparam int RAM_SIZE   = `IMG_W * `IMG_H;
  localparam int FRAME_CYC  = `H_TOTAL * `V_TOTAL;
  localparam int BOOT_LIMIT = 200000;

  logic      clk = 1'b0;
  logic      rst_n;
  nibble_t   mem_rdata;
  logic      mem_rvalid;
  logic      mem_credit;
  logic      mem_req;
  mem_cmd_e  mem_cmd;
  mem_dev_e  mem_dev;
  mem_addr_t mem_addr;
  nibble_t   mem_wdata;
  nibble_t   pixel;
  logic      hsync;
  logic      vsync;
  logic      boot_done;

  // reference position, aligned at reset
  int tb_x = 0;
  int tb_y = 0;
  int cyc = 0;
  int outstanding = 0;
  int req_num = 0;
  int last_hs_fall = -1;
  int last_vs_fall = -1;
  logic prev_hs = 1'b1;
  logic prev_vs = 1'b1;
  bit prev_req = 1'b0;
  bit boot_seen = 1'b0;
  bit check_frame = 1'b0;
  bit written [RAM_SIZE];

  int err_reset = 0;
  int err_boot = 0;
  int err_credit = 0;
  int err_pixel = 0;
  int err_sync = 0;
  int timeouts = 0;

  always #20 clk = ~clk;

  tinygpu_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mem_rdata  (mem_rdata),
    .i_mem_rvalid (mem_rvalid),
    .i_mem_credit (mem_credit),
    .o_mem_req    (mem_req),
    .o_mem_cmd    (mem_cmd),
    .o_mem_dev    (mem_dev),
    .o_mem_addr   (mem_addr),
    .o_mem_wdata  (mem_wdata),
    .o_pixel      (pixel),
    .o_hsync      (hsync),
    .o_vsync      (vsync),
    .o_boot_done  (boot_done)
  );

  tb_mem_model #(
    .LINE_COUNT (LINE_COUNT)
  ) i_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_req    (mem_req),
    .i_cmd    (mem_cmd),
    .i_dev    (mem_dev),
    .i_addr   (mem_addr),
    .i_wdata  (mem_wdata),
    .o_rdata  (mem_rdata),
    .o_rvalid (mem_rvalid),
    .o_credit (mem_credit)
  );

  always @(posedge clk) begin
    if (!rst_n) begin
      tb_x <= 0;
      tb_y <= 0;
    end else if (tb_x == `H_TOTAL - 1) begin
      tb_x <= 0;
      tb_y <= (tb_y == `V_TOTAL - 1) ? 0 : tb_y + 1;
    end else begin
      tb_x <= tb_x + 1;
    end
  end

  // outputs held by reset
  task automatic check_idle();
    assert (mem_req === 1'b0 && boot_done === 1'b0) else begin
      err_reset++;
      $display("ERR o_mem_req/o_boot_done in reset: got %h/%h expected 0/0", mem_req, boot_done);
    end
    assert (pixel === 4'h0) else begin
      err_reset++;
      $display("ERR o_pixel in reset: got %h expected 0", pixel);
    end
    assert (hsync === 1'b1 && vsync === 1'b1) else begin
      err_reset++;
      $display("ERR o_hsync/o_vsync in reset: got %h/%h expected 1/1", hsync, vsync);
    end
  endtask

  // first two requests fetch the count nibbles
  task automatic check_header_read(input int n);
    assert (mem_cmd == CMD_READ && mem_dev == DEV_FLASH) else begin
      err_boot++;
      $display("ERR o_mem_cmd/o_mem_dev on request %0d: got %h/%h expected %h/%h",
               n, mem_cmd, mem_dev, CMD_READ, DEV_FLASH);
    end
    assert (mem_addr === mem_addr_t'(n - 1)) else begin
      err_boot++;
      $display("ERR o_mem_addr on request %0d: got %h expected %h", n, mem_addr, n - 1);
    end
  endtask

  task automatic check_write();
    int      a;
    nibble_t exp_data;
    a = int'(mem_addr);
    assert (mem_dev == DEV_RAM) else begin
      err_boot++;
      $display("ERR o_mem_dev on write: got %h expected %h", mem_dev, DEV_RAM);
    end
    assert (a < RAM_SIZE) else begin
      err_boot++;
      $display("write to address %h lies outside the front buffer", mem_addr);
    end
    if (a < RAM_SIZE) begin
      assert (!written[a]) else begin
        err_boot++;
        $display("RAM address %h written more than once", mem_addr);
      end
      written[a] = 1'b1;
      // copied lines come from flash, past them black
      exp_data = (a < COPY_LEN) ? i_mem.flash[a + `FLASH_IMG_BASE] : nibble_t'(0);
      assert (mem_wdata === exp_data) else begin
        err_boot++;
        $display("ERR o_mem_wdata at %h: got %h expected %h", mem_addr, mem_wdata, exp_data);
      end
    end
  endtask

  always @(negedge clk) begin : monitor
    nibble_t exp_pix;
    logic    exp_hs;
    logic    exp_vs;
    int      a;
    int      missing;
    cyc++;

    // sync windows from the reference counters
    exp_hs = !(tb_x >= `HS_START && tb_x < `HS_END);
    exp_vs = !(tb_y >= `VS_START && tb_y < `VS_END);
    assert (hsync === exp_hs) else begin
      err_sync++;
      $display("ERR o_hsync at x=%0d y=%0d: got %h expected %h", tb_x, tb_y, hsync, exp_hs);
    end
    assert (vsync === exp_vs) else begin
      err_sync++;
      $display("ERR o_vsync at x=%0d y=%0d: got %h expected %h", tb_x, tb_y, vsync, exp_vs);
    end
    // line and frame length, fall to fall
    if (prev_hs === 1'b1 && hsync === 1'b0) begin
      if (last_hs_fall >= 0) begin
        assert (cyc - last_hs_fall == `H_TOTAL) else begin
          err_sync++;
          $display("line lasted %0d clocks instead of %0d", cyc - last_hs_fall, `H_TOTAL);
        end
      end
      last_hs_fall = cyc;
    end
    if (prev_vs === 1'b1 && vsync === 1'b0) begin
      if (last_vs_fall >= 0) begin
        assert (cyc - last_vs_fall == FRAME_CYC) else begin
          err_sync++;
          $display("frame lasted %0d clocks instead of %0d", cyc - last_vs_fall, FRAME_CYC);
        end
      end
      last_vs_fall = cyc;
    end
    prev_hs = hsync;
    prev_vs = vsync;

    // in flight at the start of this cycle
    outstanding = outstanding + int'(prev_req) - int'(mem_credit === 1'b1);
    assert (outstanding >= 0 && outstanding <= `MEM_CREDITS) else begin
      err_credit++;
      $display("outstanding request count left its range at %0d", outstanding);
    end
    if (mem_req === 1'b1) begin
      assert (outstanding < `MEM_CREDITS) else begin
        err_credit++;
        $display("request issued while %0d requests were outstanding", outstanding);
      end
      req_num++;
      if (req_num <= 2) begin
        check_header_read(req_num);
      end
      if (boot_done !== 1'b1 && mem_cmd == CMD_WRITE) begin
        check_write();
      end
    end
    prev_req = (mem_req === 1'b1);

    // whole buffer written once boot ends
    if (boot_done === 1'b1 && !boot_seen) begin
      boot_seen = 1'b1;
      missing = 0;
      for (a = 0; a < RAM_SIZE; a++) begin
        if (!written[a]) begin
          missing++;
        end
      end
      assert (missing == 0) else begin
        err_boot++;
        $display("%0d RAM addresses were not written before boot finished", missing);
      end
    end

    // black before boot, image corner during the checked frame
    if (boot_done !== 1'b1 || check_frame) begin
      exp_pix = '0;
      if (boot_done === 1'b1 && tb_x < `IMG_W && tb_y < `IMG_H) begin
        exp_pix = i_mem.ram[tb_y * `IMG_W + tb_x];
      end
      assert (pixel === exp_pix) else begin
        err_pixel++;
        $display("ERR o_pixel at x=%0d y=%0d: got %h expected %h", tb_x, tb_y, pixel, exp_pix);
      end
    end
  end

  task automatic wait_boot(output bit ok);
    int n;
    n = 0;
    while (boot_done !== 1'b1 && n < BOOT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    ok = (boot_done === 1'b1);
    if (!ok) begin
      timeouts++;
      $display("boot did not finish within %0d cycles", BOOT_LIMIT);
    end
  endtask

  // always moves at least one cycle
  task automatic wait_for_pos(input int y, input int x, input int limit, output bit ok);
    int n;
    n = 0;
    @(negedge clk);
    while (!(tb_y == y && tb_x == x) && n < limit) begin
      @(negedge clk);
      n++;
    end
    ok = (tb_y == y && tb_x == x);
    if (!ok) begin
      timeouts++;
      $display("screen position x=%0d y=%0d not reached within %0d cycles", x, y, limit);
    end
  endtask

  initial begin : main
    bit ok;
    ok = 1'b1;
    rst_n = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_idle();
    end
    rst_n <= 1'b1;

    wait_boot(ok);
    // line 0 fetch must start after boot
    if (ok) begin
      wait_for_pos(`V_TOTAL - 1, 0, FRAME_CYC + 10, ok);
    end
    if (ok) begin
      wait_for_pos(`V_TOTAL - 1, `H_TOTAL - 1, `H_TOTAL + 10, ok);
    end
    // one full frame of pixel checks
    if (ok) begin
      check_frame <= 1'b1;
      wait_for_pos(`V_TOTAL - 1, `H_TOTAL - 1, FRAME_CYC + 10, ok);
    end
    check_frame <= 1'b0;
    @(negedge clk);

    $display("error counts: reset %0d, boot %0d, credit %0d, pixel %0d, sync %0d, timeout %0d",
             err_reset, err_boot, err_credit, err_pixel, err_sync, timeouts);
    if (err_reset + err_boot + err_credit + err_pixel + err_sync + timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/tinygpu_pkg.sv
design/vga_timing.sv
design/mem_credit_port.sv
loader/image_loader.sv
scanout/line_fetcher.sv
scanout/pixel_out.sv
design/tinygpu_top.sv
sim/tb_mem_model.sv
sim/tb_tinygpu.sv

// ==== Bender.yml ====
package:
  name: tinygpu

sources:
  - include_dirs:
      - common
    files:
      - common/tinygpu_pkg.sv
      - design/vga_timing.sv
      - design/mem_credit_port.sv
      - loader/image_loader.sv
      - scanout/line_fetcher.sv
      - scanout/pixel_out.sv
      - design/tinygpu_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_mem_model.sv
      - sim/tb_tinygpu.sv
